//--- bench/i2cSlaveModel.sv
/*
 * Behavioural I2C slave with wired-AND bus lines, start and stop
 * detection, byte capture and a selectable ACK or NACK
 */
`timescale 1ns/1ns
module i2cSlaveModel
(
  input  logic        SCLO,
  input  logic        SDAO,
  input  logic        ackEnable,
  output logic        scl,
  output logic        sda,
  output logic [7:0]  lastByte,
  output logic [15:0] byteCount,
  output logic [15:0] startCount,
  output logic [15:0] stopCount
);

  logic        sdaDrive = 1'b1;
  logic        inAck    = 1'b0;
  logic        sclLast  = 1'b1;
  logic        sdaLast  = 1'b1;
  logic [3:0]  bitCount = 4'd0;
  logic [7:0]  shiftReg = 8'h00;
  logic [7:0]  captured = 8'h00;
  logic [15:0] bytes    = 16'd0;
  logic [15:0] starts   = 16'd0;
  logic [15:0] stops    = 16'd0;

  // The slave never stretches the clock
  assign scl = SCLO;
  assign sda = SDAO & sdaDrive;

  always @(scl, sda)
  begin
    if (scl === 1'b1 && sclLast === 1'b1 && sdaLast === 1'b1 && sda === 1'b0)
    begin
      starts   = starts + 16'd1;
      bitCount = 4'd0;
      inAck    = 1'b0;
      sdaDrive = 1'b1;
    end
    else if (scl === 1'b1 && sclLast === 1'b1 && sdaLast === 1'b0 && sda === 1'b1)
    begin
      stops    = stops + 16'd1;
      bitCount = 4'd0;
    end
    else if (sclLast === 1'b0 && scl === 1'b1)
    begin
      if (bitCount < 4'd8)
      begin
        shiftReg = {shiftReg[6:0], sda};
        bitCount = bitCount + 4'd1;
        if (bitCount == 4'd8)
        begin
          captured = shiftReg;
          bytes    = bytes + 16'd1;
        end
      end
    end
    else if (sclLast === 1'b1 && scl === 1'b0)
    begin
      // The ACK slot runs from the eighth falling edge to the ninth
      if (inAck)
      begin
        sdaDrive = 1'b1;
        inAck    = 1'b0;
        bitCount = 4'd0;
      end
      else if (bitCount == 4'd8)
      begin
        sdaDrive = !ackEnable;
        inAck    = 1'b1;
      end
    end
    sclLast = scl;
    sdaLast = sda;
  end

  assign lastByte   = captured;
  assign byteCount  = bytes;
  assign startCount = starts;
  assign stopCount  = stops;

endmodule

//--- bench/tbI2cMaster.sv
/*
 * Testbench for the I2C master: clock, reset, APB tasks, random transfers
 * checked against a reference model, SCL timing monitor and watchdog
 */
`timescale 1ns/1ns
module tbI2cMaster;
  import i2cPkg::*;

  localparam int testCount  = 12;
  localparam int waitLimit  = 4000;
  localparam int watchdogNs = 2 * testCount * 6 * 9 * 4 * 20 * 4;

  logic        PCLK;
  logic        reset;
  logic        PSEL;
  logic        PENABLE;
  logic        PWRITE;
  logic [4:0]  PADDR;
  logic [7:0]  PWDATA;
  logic [7:0]  PRDATA;
  logic        INT;
  logic        SCLO;
  logic        SDAO;
  logic        scl;
  logic        sda;
  logic        ackEnable;
  logic [7:0]  lastByte;
  logic [15:0] byteCount;
  logic [15:0] startCount;
  logic [15:0] stopCount;

  int          errorCount;
  int          checkCount;
  logic [2:0]  currentSel;
  logic        measuring;
  int          highCount;
  logic        sclWasHigh;
  logic        pulseMeasured;

  i2cMaster u_dut
  (
    .PCLK    (PCLK),
    .reset   (reset),
    .PSEL    (PSEL),
    .PENABLE (PENABLE),
    .PWRITE  (PWRITE),
    .PADDR   (PADDR),
    .PWDATA  (PWDATA),
    .PRDATA  (PRDATA),
    .INT     (INT),
    .SCLI    (scl),
    .SDAI    (sda),
    .SCLO    (SCLO),
    .SDAO    (SDAO)
  );

  i2cSlaveModel u_slave
  (
    .SCLO       (SCLO),
    .SDAO       (SDAO),
    .ackEnable  (ackEnable),
    .scl        (scl),
    .sda        (sda),
    .lastByte   (lastByte),
    .byteCount  (byteCount),
    .startCount (startCount),
    .stopCount  (stopCount)
  );

  always #2 PCLK = ~PCLK;

  function automatic logic [7:0] controlByte(input logic [2:0] sel, input logic sta,
                                             input logic sto, input logic si);
    return {sel[2], 1'b1, sta, sto, si, 1'b0, sel[1:0]};
  endfunction

  function automatic int quarterOf(input logic [2:0] sel);
    case (sel)
      3'd0:    return 4;
      3'd1:    return 5;
      3'd2:    return 6;
      3'd3:    return 8;
      3'd4:    return 10;
      3'd5:    return 12;
      3'd6:    return 16;
      default: return 20;
    endcase
  endfunction

  // Status byte after the ACK slot, from the code table
  function automatic logic [7:0] expectedStatus(input logic firstByte, input logic acked);
    if (firstByte)
      return acked ? 8'h18 : 8'h20;
    else
      return acked ? 8'h28 : 8'h30;
  endfunction

  task automatic checkValue(input string name, input logic [15:0] actual,
                            input logic [15:0] expected);
    checkCount++;
    assert (actual === expected)
    else
    begin
      $display("ERR %0t ns %s expected %0h actual %0h", $time, name, expected, actual);
      errorCount++;
    end
  endtask

  task automatic apbWrite(input logic [4:0] addr, input logic [7:0] data);
    @(negedge PCLK);
    PSEL    = 1'b1;
    PWRITE  = 1'b1;
    PENABLE = 1'b0;
    PADDR   = addr;
    PWDATA  = data;
    @(negedge PCLK);
    PENABLE = 1'b1;
    @(negedge PCLK);
    PSEL    = 1'b0;
    PENABLE = 1'b0;
    PWRITE  = 1'b0;
  endtask

  task automatic apbRead(input logic [4:0] addr, output logic [7:0] data);
    @(negedge PCLK);
    PSEL    = 1'b1;
    PWRITE  = 1'b0;
    PENABLE = 1'b0;
    PADDR   = addr;
    @(negedge PCLK);
    PENABLE = 1'b1;
    @(negedge PCLK);
    data    = PRDATA;
    PSEL    = 1'b0;
    PENABLE = 1'b0;
  endtask

  task automatic waitForInt(input string what);
    int cycles;
    cycles = 0;
    while (INT !== 1'b1 && cycles < waitLimit)
    begin
      @(negedge PCLK);
      cycles++;
    end
    checkCount++;
    assert (INT === 1'b1)
    else
    begin
      $display("Timed out waiting for INT after the %s", what);
      errorCount++;
    end
  endtask

  task automatic waitForStop(input logic [15:0] stopsBefore);
    int   cycles;
    logic intSeen;
    cycles  = 0;
    intSeen = 1'b0;
    while (stopCount == stopsBefore && cycles < waitLimit)
    begin
      @(negedge PCLK);
      cycles++;
      if (INT !== 1'b0)
        intSeen = 1'b1;
    end
    checkCount++;
    assert (stopCount != stopsBefore)
    else
    begin
      $display("Timed out waiting for the slave to see a stop condition");
      errorCount++;
    end
    checkCount++;
    assert (!intSeen)
    else
    begin
      $display("ERR %0t ns INT expected 0 actual 1 during the stop", $time);
      errorCount++;
    end
  endtask

  task automatic runTransfer(input int index);
    logic [7:0]  bytes [5];
    logic        acks [5];
    logic [2:0]  sel;
    logic [7:0]  readValue;
    logic [15:0] countBefore;
    int          byteTotal;
    int          errorsBefore;
    int          i;
    errorsBefore = errorCount;
    sel          = $urandom % 8;
    byteTotal    = 2 + $urandom % 4;
    for (i = 0; i < byteTotal; i++)
    begin
      bytes[i] = $urandom;
      acks[i]  = $urandom % 2;
    end
    currentSel = sel;

    countBefore = startCount;
    apbWrite(controlAddr, controlByte(sel, 1'b1, 1'b0, 1'b0));
    waitForInt("start request");
    checkValue("slave start count", startCount - countBefore, 16'd1);
    apbRead(statusAddr, readValue);
    checkValue("status", readValue, 8'h08);
    apbRead(controlAddr, readValue);
    checkValue("control", readValue, controlByte(sel, 1'b0, 1'b0, 1'b1));

    // The first byte after the start is the address byte
    for (i = 0; i < byteTotal; i++)
    begin
      ackEnable   = acks[i];
      countBefore = byteCount;
      apbWrite(dataAddr, bytes[i]);
      measuring = 1'b1;
      apbWrite(controlAddr, controlByte(sel, 1'b0, 1'b0, 1'b0));
      waitForInt("byte transfer");
      measuring = 1'b0;
      checkValue("slave byte", lastByte, bytes[i]);
      checkValue("slave byte count", byteCount - countBefore, 16'd1);
      apbRead(dataAddr, readValue);
      checkValue("data", readValue, bytes[i]);
      apbRead(statusAddr, readValue);
      checkValue("status", readValue, expectedStatus(i == 0, acks[i]));
      checkValue("INT", INT, 16'd1);
    end

    countBefore = stopCount;
    apbWrite(controlAddr, controlByte(sel, 1'b0, 1'b1, 1'b0));
    waitForStop(countBefore);
    apbRead(statusAddr, readValue);
    checkValue("status", readValue, 8'hF8);
    apbRead(controlAddr, readValue);
    checkValue("control", readValue, controlByte(sel, 1'b0, 1'b0, 1'b0));
    checkValue("INT", INT, 16'd0);

    $display("Test %0d: baud select %0d, %0d bytes, %0d errors",
             index + 1, sel, byteTotal, errorCount - errorsBefore);
  endtask

  // SCL high time in PCLK cycles, for pulses that begin inside a byte
  always @(negedge PCLK)
  begin
    if (scl === 1'b1)
    begin
      if (!sclWasHigh)
      begin
        highCount     = 0;
        pulseMeasured = measuring;
      end
      highCount  = highCount + 1;
      sclWasHigh = 1'b1;
    end
    else
    begin
      if (sclWasHigh && pulseMeasured)
      begin
        checkCount++;
        assert (highCount == 2 * quarterOf(currentSel))
        else
        begin
          $display("ERR %0t ns SCL high cycles expected %0d actual %0d",
                   $time, 2 * quarterOf(currentSel), highCount);
          errorCount++;
        end
      end
      sclWasHigh = 1'b0;
    end
  end

  initial
  begin
    #(watchdogNs);
    $display("Watchdog expired before all transfers completed");
    $display("RESULT: FAIL");
    $finish;
  end

  initial
  begin
    logic [7:0] readValue;
    int         t;
    PCLK          = 1'b0;
    reset         = 1'b1;
    PSEL          = 1'b0;
    PENABLE       = 1'b0;
    PWRITE        = 1'b0;
    PADDR         = 5'd0;
    PWDATA        = 8'h00;
    ackEnable     = 1'b1;
    measuring     = 1'b0;
    currentSel    = 3'd0;
    highCount     = 0;
    sclWasHigh    = 1'b0;
    pulseMeasured = 1'b0;
    errorCount    = 0;
    checkCount    = 0;
    void'($urandom(63));

    repeat (16) @(posedge PCLK);
    @(negedge PCLK);
    reset = 1'b0;

    checkValue("INT", INT, 16'd0);
    checkValue("SCLO", SCLO, 16'd1);
    checkValue("SDAO", SDAO, 16'd1);
    apbRead(controlAddr, readValue);
    checkValue("control", readValue, 8'h00);
    apbRead(statusAddr, readValue);
    checkValue("status", readValue, 8'hF8);
    $display("Test 0: reset values, %0d errors", errorCount);

    for (t = 0; t < testCount; t++)
      runTransfer(t);

    $display("Summary: %0d tests, %0d checks, %0d errors",
             testCount + 1, checkCount, errorCount);
    if (errorCount == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

//--- source/apbRegisterFile.sv
/*
 * Control register with hardware set and clear rules, data write strobe
 * and the read mux for control, status and data
 */
`timescale 1ns/1ns
module apbRegisterFile
(
  input  logic                PCLK,
  input  logic                reset,
  input  logic                PSEL,
  input  logic                PENABLE,
  input  logic                PWRITE,
  input  logic [4:0]          PADDR,
  input  logic [7:0]          PWDATA,
  input  i2cPkg::fsmEvents_t  events,
  input  logic [4:0]          statusCode,
  input  logic [7:0]          dataByte,
  output i2cPkg::controlReg_t control,
  output logic                dataWrite,
  output logic [7:0]          PRDATA
);
  import i2cPkg::*;

  logic        writeEnable;
  controlReg_t written;
  controlReg_t controlNext;

  assign writeEnable = PSEL && PENABLE && PWRITE;
  assign dataWrite   = writeEnable && (PADDR == dataAddr);
  assign written     = PWDATA;

  always_comb
  begin
    controlNext = control;
    if (writeEnable && PADDR == controlAddr)
    begin
      controlNext = written;
      // Software can only clear the interrupt flag
      controlNext.si = control.si && written.si;
    end
    if (events.setSi)
      controlNext.si = 1'b1;
    if (events.clearSto)
      controlNext.sto = 1'b0;
    if (events.clearSta)
      controlNext.sta = 1'b0;
    controlNext.si = controlNext.si && controlNext.ens1;
  end

  always_ff @(posedge PCLK)
  begin
    if (reset)
      control <= '0;
    else
      control <= controlNext;
  end

  always_comb
  begin
    case (PADDR)
      controlAddr: PRDATA = control;
      statusAddr:  PRDATA = {statusCode, 3'b000};
      dataAddr:    PRDATA = dataByte;
      default:     PRDATA = 8'h00;
    endcase
  end

  assert property (@(posedge PCLK) disable iff (reset)
    events.setSi |-> control.ens1);

endmodule

//--- source/i2cBitTimer.sv
/*
 * Baud divider giving quarter-bit ticks and the quarter index
 * within the current bit
 */
`timescale 1ns/1ns
module i2cBitTimer
(
  input  logic              PCLK,
  input  logic              reset,
  input  logic              run,
  input  logic [2:0]        baudSelect,
  output i2cPkg::bitPhase_t phase
);
  import i2cPkg::*;

  logic [7:0] quarterCount;
  logic [1:0] quarterIndex;
  logic       tick;

  // Last cycle of a quarter
  assign tick = run && (quarterCount == quarterCycles[baudSelect] - 8'd1);

  always_ff @(posedge PCLK)
  begin
    if (reset || !run)
    begin
      quarterCount <= 8'd0;
      quarterIndex <= 2'd0;
    end
    else if (tick)
    begin
      quarterCount <= 8'd0;
      quarterIndex <= quarterIndex + 2'd1;
    end
    else
    begin
      quarterCount <= quarterCount + 8'd1;
    end
  end

  assign phase.tick    = tick;
  assign phase.quarter = quarterIndex;

endmodule

//--- source/i2cDataShifter.sv
/*
 * Data register with MSB-first shift-out and the bit counter
 */
`timescale 1ns/1ns
module i2cDataShifter
(
  input  logic       PCLK,
  input  logic       reset,
  input  logic       dataWrite,
  input  logic [7:0] writeData,
  input  logic       loadShift,
  input  logic       shiftBit,
  output logic       txBit,
  output logic       byteDone,
  output logic [7:0] dataByte
);

  logic [7:0] dataReg;
  logic [3:0] bitCount;

  // Rotating keeps the written byte readable after a full transfer
  always_ff @(posedge PCLK)
  begin
    if (dataWrite)
      dataReg <= writeData;
    else if (shiftBit)
      dataReg <= {dataReg[6:0], dataReg[7]};
  end

  always_ff @(posedge PCLK)
  begin
    if (reset || loadShift)
      bitCount <= 4'd0;
    else if (shiftBit)
      bitCount <= bitCount + 4'd1;
  end

  assign txBit    = dataReg[7];
  assign byteDone = (bitCount == 4'd8);
  assign dataByte = dataReg;

endmodule

//--- source/i2cLineFilter.sv
/*
 * Glitch filter on SCL and SDA with start and stop detection
 * and the bus-busy level
 */
`timescale 1ns/1ns
module i2cLineFilter
(
  input  logic               PCLK,
  input  logic               reset,
  input  logic               enable,
  input  logic               SCLI,
  input  logic               SDAI,
  output i2cPkg::lineState_t line
);
  import i2cPkg::*;

  logic [glitchDepth-1:0] sclShift;
  logic [glitchDepth-1:0] sdaShift;
  logic sclLevel;
  logic sdaLevel;
  logic sclLast;
  logic sdaLast;
  logic busBusy;
  logic startSeen;
  logic stopSeen;

  always_ff @(posedge PCLK)
  begin
    if (reset || !enable)
    begin
      sclShift <= '1;
      sdaShift <= '1;
      sclLevel <= 1'b1;
      sdaLevel <= 1'b1;
      sclLast  <= 1'b1;
      sdaLast  <= 1'b1;
      busBusy  <= 1'b0;
    end
    else
    begin
      sclShift <= {sclShift[glitchDepth-2:0], SCLI};
      sdaShift <= {sdaShift[glitchDepth-2:0], SDAI};
      // A level is only taken once every stage agrees
      if (&sclShift)
        sclLevel <= 1'b1;
      else if (~|sclShift)
        sclLevel <= 1'b0;
      if (&sdaShift)
        sdaLevel <= 1'b1;
      else if (~|sdaShift)
        sdaLevel <= 1'b0;
      sclLast <= sclLevel;
      sdaLast <= sdaLevel;
      if (startSeen)
        busBusy <= 1'b1;
      else if (stopSeen)
        busBusy <= 1'b0;
    end
  end

  // SDA edges while SCL stays high mark start and stop
  assign startSeen = sclLevel && sclLast && sdaLast && !sdaLevel;
  assign stopSeen  = sclLevel && sclLast && !sdaLast && sdaLevel;

  assign line.scl       = sclLevel;
  assign line.sda       = sdaLevel;
  assign line.busBusy   = busBusy;
  assign line.startSeen = startSeen;

  assert property (@(posedge PCLK) disable iff (reset || !enable)
    startSeen |-> !busBusy);

endmodule

//--- source/i2cMaster.sv
/*
 * I2C master transmitter top level on the APB register bus
 */
`timescale 1ns/1ns
module i2cMaster
(
  input  logic       PCLK,
  input  logic       reset,
  input  logic       PSEL,
  input  logic       PENABLE,
  input  logic       PWRITE,
  input  logic [4:0] PADDR,
  input  logic [7:0] PWDATA,
  output logic [7:0] PRDATA,
  output logic       INT,
  input  logic       SCLI,
  input  logic       SDAI,
  output logic       SCLO,
  output logic       SDAO
);
  import i2cPkg::*;

  controlReg_t control;
  lineState_t  line;
  bitPhase_t   phase;
  fsmEvents_t  events;
  logic [4:0]  statusCode;
  logic [7:0]  dataByte;
  logic        dataWrite;
  logic        run;
  logic        txBit;
  logic        byteDone;

  assign INT = control.si;

  i2cLineFilter u_filter
  (
    .PCLK   (PCLK),
    .reset  (reset),
    .enable (control.ens1),
    .SCLI   (SCLI),
    .SDAI   (SDAI),
    .line   (line)
  );

  i2cBitTimer u_timer
  (
    .PCLK       (PCLK),
    .reset      (reset),
    .run        (run),
    .baudSelect ({control.cr2, control.cr10}),
    .phase      (phase)
  );

  i2cDataShifter u_shifter
  (
    .PCLK      (PCLK),
    .reset     (reset),
    .dataWrite (dataWrite),
    .writeData (PWDATA),
    .loadShift (events.loadShift),
    .shiftBit  (events.shiftBit),
    .txBit     (txBit),
    .byteDone  (byteDone),
    .dataByte  (dataByte)
  );

  i2cMasterFsm u_fsm
  (
    .PCLK       (PCLK),
    .reset      (reset),
    .control    (control),
    .line       (line),
    .phase      (phase),
    .txBit      (txBit),
    .byteDone   (byteDone),
    .run        (run),
    .events     (events),
    .statusCode (statusCode),
    .SCLO       (SCLO),
    .SDAO       (SDAO)
  );

  apbRegisterFile u_regs
  (
    .PCLK       (PCLK),
    .reset      (reset),
    .PSEL       (PSEL),
    .PENABLE    (PENABLE),
    .PWRITE     (PWRITE),
    .PADDR      (PADDR),
    .PWDATA     (PWDATA),
    .events     (events),
    .statusCode (statusCode),
    .dataByte   (dataByte),
    .control    (control),
    .dataWrite  (dataWrite),
    .PRDATA     (PRDATA)
  );

endmodule

//--- source/i2cMasterFsm.sv
/*
 * Master transmit FSM: start, byte and ACK bits, stop, SCL/SDA drive
 * and the status code
 */
`timescale 1ns/1ns
module i2cMasterFsm
(
  input  logic                PCLK,
  input  logic                reset,
  input  i2cPkg::controlReg_t control,
  input  i2cPkg::lineState_t  line,
  input  i2cPkg::bitPhase_t   phase,
  input  logic                txBit,
  input  logic                byteDone,
  output logic                run,
  output i2cPkg::fsmEvents_t  events,
  output logic [4:0]          statusCode,
  output logic                SCLO,
  output logic                SDAO
);
  import i2cPkg::*;

  typedef enum logic [2:0] {
    idle, waitFree, startHold, hold, sendBit, ackBit, stopLow, stopHigh
  } state_t;

  state_t     state;
  state_t     stateNext;
  logic       sdaOut;
  logic       sdaNext;
  logic       addrByte;
  logic       addrNext;
  logic       nack;
  logic       nackNext;
  logic [4:0] statusNext;

  always_comb
  begin
    stateNext  = state;
    sdaNext    = sdaOut;
    addrNext   = addrByte;
    nackNext   = nack;
    statusNext = statusCode;
    events     = '0;
    case (state)
      idle:
        if (control.sta)
          stateNext = waitFree;
      waitFree:
        if (!line.busBusy && !line.startSeen && line.scl)
        begin
          stateNext = startHold;
          sdaNext   = 1'b0;
        end
      startHold:
        if (phase.tick && phase.quarter == 2'd1)
        begin
          stateNext       = hold;
          addrNext        = 1'b1;
          statusNext      = statusStart;
          events.setSi    = 1'b1;
          events.clearSta = 1'b1;
        end
      hold:
        if (!control.si)
        begin
          if (control.sto)
            stateNext = stopLow;
          else
          begin
            stateNext        = sendBit;
            events.loadShift = 1'b1;
          end
        end
      sendBit:
      begin
        // Eight data bits, then the ninth bit becomes the ACK slot
        if (phase.tick && phase.quarter == 2'd0)
        begin
          if (byteDone)
          begin
            stateNext = ackBit;
            sdaNext   = 1'b1;
          end
          else
            sdaNext = txBit;
        end
        if (phase.tick && phase.quarter == 2'd3)
          events.shiftBit = 1'b1;
      end
      ackBit:
      begin
        if (phase.tick && phase.quarter == 2'd2)
          nackNext = line.sda;
        if (phase.tick && phase.quarter == 2'd3)
        begin
          stateNext    = hold;
          addrNext     = 1'b0;
          events.setSi = 1'b1;
          if (addrByte)
            statusNext = nack ? statusAddrNack : statusAddrAck;
          else
            statusNext = nack ? statusDataNack : statusDataAck;
        end
      end
      stopLow:
      begin
        if (phase.tick && phase.quarter == 2'd0)
          sdaNext = 1'b0;
        if (phase.tick && phase.quarter == 2'd1)
          stateNext = stopHigh;
      end
      default:
        if (phase.tick && phase.quarter == 2'd2)
        begin
          stateNext       = idle;
          sdaNext         = 1'b1;
          statusNext      = statusIdle;
          events.clearSto = 1'b1;
        end
    endcase
    if (!control.ens1)
    begin
      stateNext  = idle;
      sdaNext    = 1'b1;
      statusNext = statusIdle;
      events     = '0;
    end
  end

  always_ff @(posedge PCLK)
  begin
    if (reset)
    begin
      state      <= idle;
      sdaOut     <= 1'b1;
      addrByte   <= 1'b0;
      nack       <= 1'b0;
      statusCode <= statusIdle;
    end
    else
    begin
      state      <= stateNext;
      sdaOut     <= sdaNext;
      addrByte   <= addrNext;
      nack       <= nackNext;
      statusCode <= statusNext;
    end
  end

  // SCL is high in the last two quarters of every bit
  always_comb
  begin
    case (state)
      sendBit, ackBit: SCLO = phase.quarter[1];
      hold, stopLow:   SCLO = 1'b0;
      default:         SCLO = 1'b1;
    endcase
  end

  assign run  = state inside {startHold, sendBit, ackBit, stopLow, stopHigh};
  assign SDAO = sdaOut;

  assert property (@(posedge PCLK) disable iff (reset)
    $changed(SDAO) && (state inside {hold, sendBit, ackBit}) |-> !SCLO);

endmodule

//--- source/i2cPkg.sv
/*
 * Register addresses, status codes, baud table and filter depth for the
 * I2C master, plus the packed structs passed between its blocks
 */
package i2cPkg;

  localparam logic [4:0] controlAddr = 5'd0;
  localparam logic [4:0] statusAddr  = 5'd4;
  localparam logic [4:0] dataAddr    = 5'd8;

  localparam int glitchDepth = 3;

  // PCLK cycles per quarter bit, indexed by {cr2, cr10}
  localparam logic [7:0] quarterCycles [8] = '{
    8'd4, 8'd5, 8'd6, 8'd8, 8'd10, 8'd12, 8'd16, 8'd20
  };

  localparam logic [4:0] statusIdle     = 5'd31;
  localparam logic [4:0] statusStart    = 5'd1;
  localparam logic [4:0] statusAddrAck  = 5'd3;
  localparam logic [4:0] statusAddrNack = 5'd4;
  localparam logic [4:0] statusDataAck  = 5'd5;
  localparam logic [4:0] statusDataNack = 5'd6;

  typedef struct packed {
    logic       cr2;
    logic       ens1;
    logic       sta;
    logic       sto;
    logic       si;
    logic       aa;
    logic [1:0] cr10;
  } controlReg_t;

  typedef struct packed {
    logic       tick;
    logic [1:0] quarter;
  } bitPhase_t;

  typedef struct packed {
    logic scl;
    logic sda;
    logic busBusy;
    logic startSeen;
  } lineState_t;

  typedef struct packed {
    logic setSi;
    logic clearSto;
    logic clearSta;
    logic loadShift;
    logic shiftBit;
  } fsmEvents_t;

endpackage

//--- tb.f
source/i2cPkg.sv
source/i2cLineFilter.sv
source/i2cBitTimer.sv
source/i2cDataShifter.sv
source/i2cMasterFsm.sv
source/apbRegisterFile.sv
source/i2cMaster.sv
bench/i2cSlaveModel.sv
bench/tbI2cMaster.sv
